// File: Bender.yml
package:
  name: mipsControl

sources:
  - mipsCtrlPkg.sv
  - instrDecode.sv
  - controlFsm.sv
  - ctrlSignalGen.sv
  - mipsControl.sv
  - target: simulation
    files:
      - mipsControl_asserts.sv
      - mipsControlTb.sv

// File: controlFsm.sv
`timescale 1ns/10ps
`default_nettype none

module controlFsm
(
	input logic Clk,
	input logic rstN,
	input mipsCtrlPkg::instrClassT instrClass,
	output mipsCtrlPkg::ctrlStateT state,
	output mipsCtrlPkg::aluOpT aluOp
);

	import mipsCtrlPkg::*;

	ctrlStateT nextState;
	aluOpT classAluOp;
	logic branchNe; // remembers bne versus beq past decode

	// R-type operation for the execute step
	always_comb
	begin
		case (instrClass)
			classAdd: classAluOp = aluAdd;
			classAnd: classAluOp = aluAnd;
			classSub: classAluOp = aluSub;
			classXor: classAluOp = aluXor;
			default: classAluOp = aluPass;
		endcase
	end

	always_comb
	begin
		case (state)
			stReset: nextState = stFetch;
			stFetch: nextState = stFetchWait1;
			stFetchWait1: nextState = stFetchWait2;
			stFetchWait2: nextState = stDecode;
			stDecode:
			begin
				case (instrClass)
					classAdd, classAnd, classSub, classXor: nextState = stAluExec;
					classNop: nextState = stNop;
					classBrk: nextState = stBrk;
					classBeq, classBne: nextState = stBranchCmp;
					classJmp: nextState = stJump;
					default: nextState = stFetch; // unknown code, refetch
				endcase
			end
			stAluExec: nextState = stRegWb;
			stBranchCmp: nextState = branchNe ? stBneResolve : stBeqResolve;
			stBrk: nextState = stBrk; // halted until reset
			default: nextState = stFetch; // regWb, nop, jump and resolves
		endcase
	end

	always_ff @(posedge Clk or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= stReset;
			aluOp <= aluPass;
			branchNe <= 1'b0;
		end
		else
		begin
			state <= nextState;
			if (state == stDecode) // instruction sampled only here
			begin
				aluOp <= classAluOp;
				branchNe <= (instrClass == classBne);
			end
		end
	end

endmodule : controlFsm

`default_nettype wire

// File: ctrlSignalGen.sv
`timescale 1ns/10ps
`default_nettype none

module ctrlSignalGen
(
	input mipsCtrlPkg::ctrlStateT state,
	input mipsCtrlPkg::aluOpT aluOp,
	input logic aluEq,
	output logic regsReset,
	output logic irWrite,
	output logic mdrLoad,
	output logic aLoad,
	output logic bLoad,
	output logic aluOutLoad,
	output logic regWrite,
	output logic regDst,
	output logic pcLoad,
	output mipsCtrlPkg::pcSrcT pcSource,
	output mipsCtrlPkg::aluOpT aluSel,
	output logic aluSrcA,
	output mipsCtrlPkg::srcBT aluSrcB
);

	import mipsCtrlPkg::*;

	always_comb
	begin
		// idle control word, overridden per state
		regsReset = 1'b0;
		irWrite = 1'b0;
		mdrLoad = 1'b0;
		aLoad = 1'b0;
		bLoad = 1'b0;
		aluOutLoad = 1'b0;
		regWrite = 1'b0;
		regDst = 1'b0;
		pcLoad = 1'b0;
		pcSource = pcSrcAlu;
		aluSel = aluPass;
		aluSrcA = 1'b0; // PC
		aluSrcB = srcBReg;

		case (state)
			stReset:
			begin
				regsReset = 1'b1; // clear all datapath registers
			end

			stFetch, stFetchWait1:
			begin
				irWrite = 1'b1; // hold memory read into IR
				mdrLoad = 1'b1;
				aluSrcB = srcBFour;
			end

			stFetchWait2:
			begin
				irWrite = 1'b1;
				mdrLoad = 1'b1;
				aluSrcB = srcBFour;
				aluSel = aluAdd; // PC + 4
				pcLoad = 1'b1;
				pcSource = pcSrcAlu;
			end

			stDecode:
			begin
				aLoad = 1'b1; // register file reads
				bLoad = 1'b1;
				aluOutLoad = 1'b1; // branch target kept for later
				aluSel = aluAdd;
				aluSrcB = srcBOffset;
			end

			stAluExec:
			begin
				aluSel = aluOp; // latched at decode
				aluSrcA = 1'b1;
				aluOutLoad = 1'b1;
			end

			stRegWb:
			begin
				regWrite = 1'b1;
				regDst = 1'b1; // rd field
			end

			stBranchCmp:
			begin
				aluSel = aluSub; // A - B sets the equal flag
				aluSrcA = 1'b1;
			end

			stBeqResolve:
			begin
				pcLoad = aluEq;
				pcSource = pcSrcAluOut;
			end

			stBneResolve:
			begin
				pcLoad = !aluEq;
				pcSource = pcSrcAluOut;
			end

			stJump:
			begin
				pcLoad = 1'b1;
				pcSource = pcSrcJump;
			end

			default:
			begin
				// nop and brk keep the idle word
			end
		endcase
	end

endmodule : ctrlSignalGen

`default_nettype wire

// File: instrDecode.sv
`timescale 1ns/10ps
`default_nettype none

module instrDecode
(
	input mipsCtrlPkg::opcodeT op,
	input mipsCtrlPkg::functT funct,
	output mipsCtrlPkg::instrClassT instrClass
);

	import mipsCtrlPkg::*;

	always_comb
	begin
		case (op)
			opFunct:
			begin
				case (funct) // only meaningful for R-type
					functAdd: instrClass = classAdd;
					functAnd: instrClass = classAnd;
					functSub: instrClass = classSub;
					functXor: instrClass = classXor;
					functNop: instrClass = classNop;
					functBreak: instrClass = classBrk;
					default: instrClass = classUnknown;
				endcase
			end

			opBeq: instrClass = classBeq;

			opBne: instrClass = classBne;

			opJ: instrClass = classJmp;

			default: instrClass = classUnknown; // LW, SW, LUI and the rest
		endcase
	end

endmodule : instrDecode

`default_nettype wire

// File: mipsControl.sv
`timescale 1ns/10ps
`default_nettype none

module mipsControl
(
	input logic Clk,
	input logic rstN,
	input mipsCtrlPkg::opcodeT op,
	input mipsCtrlPkg::functT funct,
	input logic aluEq,
	output logic regsReset,
	output logic irWrite,
	output logic mdrLoad,
	output logic aLoad,
	output logic bLoad,
	output logic aluOutLoad,
	output logic regWrite,
	output logic regDst,
	output logic pcLoad,
	output mipsCtrlPkg::pcSrcT pcSource,
	output mipsCtrlPkg::aluOpT aluSel,
	output logic aluSrcA,
	output mipsCtrlPkg::srcBT aluSrcB
);

	import mipsCtrlPkg::*;

	instrClassT instrClass;
	ctrlStateT state;
	aluOpT aluOp; // R-type operation held from decode

	instrDecode uDecode
	(
		.op(op),
		.funct(funct),
		.instrClass(instrClass)
	);

	controlFsm uFsm
	(
		.Clk(Clk),
		.rstN(rstN),
		.instrClass(instrClass),
		.state(state),
		.aluOp(aluOp)
	);

	ctrlSignalGen uSigGen
	(
		.state(state),
		.aluOp(aluOp),
		.aluEq(aluEq),
		.regsReset(regsReset),
		.irWrite(irWrite),
		.mdrLoad(mdrLoad),
		.aLoad(aLoad),
		.bLoad(bLoad),
		.aluOutLoad(aluOutLoad),
		.regWrite(regWrite),
		.regDst(regDst),
		.pcLoad(pcLoad),
		.pcSource(pcSource),
		.aluSel(aluSel),
		.aluSrcA(aluSrcA),
		.aluSrcB(aluSrcB)
	);

endmodule : mipsControl

`default_nettype wire

// File: mipsControlTb.sv
`timescale 1ns/10ps
`default_nettype none

module mipsControlTb;

	import mipsCtrlPkg::*;

	localparam int numInstr = 400;
	localparam int clkPeriod = 8;
	localparam int timeoutNs = numInstr * 6 * clkPeriod * 2; // worst case 6 cycles each, doubled

	logic Clk;
	logic rstN;
	opcodeT op;
	functT funct;
	logic aluEq;
	logic regsReset, irWrite, mdrLoad, aLoad, bLoad, aluOutLoad;
	logic regWrite, regDst, pcLoad, aluSrcA;
	pcSrcT pcSource;
	aluOpT aluSel;
	srcBT aluSrcB;

	int errorCount = 0;
	int checkCount = 0;
	string testName = "reset";

	mipsControl dut
	(
		.Clk(Clk), .rstN(rstN), .op(op), .funct(funct), .aluEq(aluEq),
		.regsReset(regsReset), .irWrite(irWrite), .mdrLoad(mdrLoad), .aLoad(aLoad),
		.bLoad(bLoad), .aluOutLoad(aluOutLoad), .regWrite(regWrite), .regDst(regDst),
		.pcLoad(pcLoad), .pcSource(pcSource), .aluSel(aluSel), .aluSrcA(aluSrcA),
		.aluSrcB(aluSrcB)
	);

	initial
	begin
		Clk = 1'b0;
		forever #(clkPeriod / 2) Clk = ~Clk;
	end

	task automatic compareValue(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("error %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	// expected control word of one step, checked mid-cycle
	task automatic checkCycle(input ctrlStateT phase, input aluOpT rOp);
		logic [9:0] eFlags; // regsReset in bit 9 down to aluSrcA in bit 0
		pcSrcT ePcSource;
		aluOpT eAluSel;
		srcBT eAluSrcB;
		@(negedge Clk);
		eFlags = '0;
		ePcSource = pcSrcAlu;
		eAluSel = aluPass;
		eAluSrcB = srcBReg;
		case (phase)
			stReset: eFlags = 10'b10_0000_0000;
			stFetch, stFetchWait1:
			begin
				eFlags = 10'b01_1000_0000;
				eAluSrcB = srcBFour;
			end
			stFetchWait2:
			begin
				eFlags = 10'b01_1000_0010; // pc + 4 written back
				eAluSrcB = srcBFour;
				eAluSel = aluAdd;
			end
			stDecode:
			begin
				eFlags = 10'b00_0111_0000;
				eAluSel = aluAdd;
				eAluSrcB = srcBOffset;
			end
			stAluExec:
			begin
				eFlags = 10'b00_0001_0001;
				eAluSel = rOp;
			end
			stRegWb: eFlags = 10'b00_0000_1100;
			stBranchCmp:
			begin
				eFlags = 10'b00_0000_0001;
				eAluSel = aluSub;
			end
			stBeqResolve, stBneResolve:
			begin
				eFlags[1] = (phase == stBeqResolve) ? aluEq : !aluEq;
				ePcSource = pcSrcAluOut;
			end
			stJump:
			begin
				eFlags[1] = 1'b1;
				ePcSource = pcSrcJump;
			end
			default: eFlags = '0; // nop and halted after break
		endcase
		compareValue({testName, " ", phase.name(), " regsReset"}, 8'(eFlags[9]), 8'(regsReset));
		compareValue({testName, " ", phase.name(), " irWrite"}, 8'(eFlags[8]), 8'(irWrite));
		compareValue({testName, " ", phase.name(), " mdrLoad"}, 8'(eFlags[7]), 8'(mdrLoad));
		compareValue({testName, " ", phase.name(), " aLoad"}, 8'(eFlags[6]), 8'(aLoad));
		compareValue({testName, " ", phase.name(), " bLoad"}, 8'(eFlags[5]), 8'(bLoad));
		compareValue({testName, " ", phase.name(), " aluOutLoad"}, 8'(eFlags[4]), 8'(aluOutLoad));
		compareValue({testName, " ", phase.name(), " regWrite"}, 8'(eFlags[3]), 8'(regWrite));
		compareValue({testName, " ", phase.name(), " regDst"}, 8'(eFlags[2]), 8'(regDst));
		compareValue({testName, " ", phase.name(), " pcLoad"}, 8'(eFlags[1]), 8'(pcLoad));
		compareValue({testName, " ", phase.name(), " aluSrcA"}, 8'(eFlags[0]), 8'(aluSrcA));
		compareValue({testName, " ", phase.name(), " pcSource"}, 8'(ePcSource), 8'(pcSource));
		compareValue({testName, " ", phase.name(), " aluSel"}, 8'(eAluSel), 8'(aluSel));
		compareValue({testName, " ", phase.name(), " aluSrcB"}, 8'(eAluSrcB), 8'(aluSrcB));
		@(posedge Clk);
		aluEq <= 1'($urandom_range(1, 0)); // new flag every cycle
	endtask

	task automatic applyReset(input int lowCycles);
		rstN <= 1'b0;
		repeat (lowCycles) checkCycle(stReset, aluPass);
		rstN <= 1'b1;
		checkCycle(stReset, aluPass); // one more cycle before fetch
	endtask

	// chooses the next instruction and drives its fields
	task automatic pickInstruction(output instrClassT kind);
		int unsigned roll;
		logic [5:0] code;
		roll = $urandom_range(99, 0);
		code = 6'($urandom);
		if (roll < 6)
		begin
			kind = classUnknown;
			while (code inside {6'h00, 6'h02, 6'h04, 6'h05})
				code = 6'($urandom);
			op <= opcodeT'(code); // LW, SW, LUI or garbage
			funct <= functT'(6'($urandom));
		end
		else if (roll < 12)
		begin
			kind = classUnknown;
			while (code inside {6'h00, 6'h0D, 6'h20, 6'h22, 6'h24, 6'h26})
				code = 6'($urandom);
			op <= opFunct;
			funct <= functT'(code);
		end
		else
		begin
			case ($urandom_range(7, 0))
				0: kind = classAdd;
				1: kind = classAnd;
				2: kind = classSub;
				3: kind = classXor;
				4: kind = classNop;
				5: kind = classBeq;
				6: kind = classBne;
				default: kind = classJmp;
			endcase
			if (roll < 15)
				kind = classBrk; // rare halt
			op <= opFunct;
			funct <= functT'(6'($urandom)); // don't care outside R-type
			case (kind)
				classAdd: funct <= functAdd;
				classAnd: funct <= functAnd;
				classSub: funct <= functSub;
				classXor: funct <= functXor;
				classNop: funct <= functNop;
				classBrk: funct <= functBreak;
				classBeq: op <= opBeq;
				classBne: op <= opBne;
				default: op <= opJ;
			endcase
		end
	endtask

	task automatic runInstruction(input int idx);
		instrClassT kind;
		aluOpT rOp;
		pickInstruction(kind);
		testName = $sformatf("instr %0d %s", idx, kind.name());
		case (kind)
			classAdd: rOp = aluAdd;
			classAnd: rOp = aluAnd;
			classSub: rOp = aluSub;
			classXor: rOp = aluXor;
			default: rOp = aluPass;
		endcase
		checkCycle(stFetch, rOp);
		checkCycle(stFetchWait1, rOp);
		checkCycle(stFetchWait2, rOp);
		checkCycle(stDecode, rOp);
		case (kind)
			classAdd, classAnd, classSub, classXor:
			begin
				checkCycle(stAluExec, rOp);
				checkCycle(stRegWb, rOp);
			end
			classNop: checkCycle(stNop, rOp);
			classJmp: checkCycle(stJump, rOp);
			classBeq, classBne:
			begin
				checkCycle(stBranchCmp, rOp);
				checkCycle((kind == classBeq) ? stBeqResolve : stBneResolve, rOp);
			end
			classBrk:
			begin
				repeat ($urandom_range(12, 2)) checkCycle(stBrk, rOp);
				testName = $sformatf("instr %0d reset after break", idx);
				applyReset(3);
			end
			default:
			begin
				// unknown code returns to fetch, seen by the next instruction's fetch
			end
		endcase
	endtask

	initial
	begin
		rstN = 1'b0;
		op = opFunct;
		funct = functNop;
		aluEq = 1'b0;
		void'($urandom(32'h4325_b18a));
		@(posedge Clk);
		applyReset(5);
		for (int i = 0; i < numInstr; i++)
			runInstruction(i);
		$display("%0d checks, %0d value errors, %0d assertion failures", checkCount, errorCount,
			dut.uAsserts.assertFails);
		if (errorCount == 0 && dut.uAsserts.assertFails == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	initial
	begin
		#(timeoutNs);
		$display("run timed out after %0d ns without finishing the instruction stream", timeoutNs);
		$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: mipsControl_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module mipsControlAsserts
(
	input logic Clk,
	input logic rstN,
	input mipsCtrlPkg::ctrlStateT state,
	input logic regsReset, irWrite, mdrLoad, aLoad, bLoad, aluOutLoad,
	input logic regWrite, regDst, pcLoad, aluSrcA,
	input mipsCtrlPkg::pcSrcT pcSource,
	input mipsCtrlPkg::aluOpT aluSel,
	input mipsCtrlPkg::srcBT aluSrcB
);

	import mipsCtrlPkg::*;

	int assertFails = 0; // read by the testbench at the end

	logic idleWord;
	assign idleWord = !(regsReset | irWrite | mdrLoad | aLoad | bLoad | aluOutLoad | regWrite
		| regDst | pcLoad | aluSrcA) && pcSource == pcSrcAlu && aluSel == aluPass
		&& aluSrcB == srcBReg;

	irWriteInFetch: assert property (@(posedge Clk) disable iff (!rstN)
		irWrite |-> state inside {stFetch, stFetchWait1, stFetchWait2})
	else
	begin
		assertFails++;
		$error("irWrite high outside the fetch cycles");
	end

	noWriteWithPcLoad: assert property (@(posedge Clk) disable iff (!rstN)
		!(regWrite && pcLoad))
	else
	begin
		assertFails++;
		$error("regWrite and pcLoad high together");
	end

	haltStaysIdle: assert property (@(posedge Clk) disable iff (!rstN)
		(state == stBrk) |-> idleWord ##1 (state == stBrk && idleWord))
	else
	begin
		assertFails++;
		$error("unit left the idle halt after a break");
	end

endmodule

bind mipsControl mipsControlAsserts uAsserts
(
	.Clk(Clk), .rstN(rstN), .state(state),
	.regsReset(regsReset), .irWrite(irWrite), .mdrLoad(mdrLoad), .aLoad(aLoad),
	.bLoad(bLoad), .aluOutLoad(aluOutLoad), .regWrite(regWrite), .regDst(regDst),
	.pcLoad(pcLoad), .aluSrcA(aluSrcA), .pcSource(pcSource), .aluSel(aluSel),
	.aluSrcB(aluSrcB)
);

`default_nettype wire

// File: mipsCtrlPkg.sv
`default_nettype none

package mipsCtrlPkg;

	localparam int opcodeW = 6;
	localparam int functW = 6;
	localparam int aluSelW = 3;
	localparam int classW = 4; // ten classes need four bits
	localparam int srcBW = 2;
	localparam int pcSrcW = 2;
	localparam int stateW = 5;

	// opcodes handled by the unit
	typedef enum logic [opcodeW-1:0]
	{
		opFunct = 6'h00, // R-type, operation in funct
		opJ = 6'h02,
		opBeq = 6'h04,
		opBne = 6'h05
	} opcodeT;

	typedef enum logic [functW-1:0]
	{
		functNop = 6'h00,
		functBreak = 6'h0D,
		functAdd = 6'h20,
		functSub = 6'h22,
		functAnd = 6'h24,
		functXor = 6'h26
	} functT;

	typedef enum logic [classW-1:0]
	{
		classAdd,
		classAnd,
		classSub,
		classXor,
		classNop,
		classBrk,
		classBeq,
		classBne,
		classJmp,
		classUnknown // anything not listed above
	} instrClassT;

	// ALU operation codes as seen by the datapath
	typedef enum logic [aluSelW-1:0]
	{
		aluPass = 3'b000,
		aluAdd = 3'b001,
		aluSub = 3'b010,
		aluAnd = 3'b011,
		aluXor = 3'b110
	} aluOpT;

	typedef enum logic [srcBW-1:0]
	{
		srcBReg = 2'b00, // register B
		srcBFour = 2'b01, // constant 4 for PC increment
		srcBOffset = 2'b11 // sign extended offset shifted by two
	} srcBT;

	typedef enum logic [pcSrcW-1:0]
	{
		pcSrcAlu = 2'b00, // live ALU result
		pcSrcAluOut = 2'b01, // branch target held in ALUOut
		pcSrcJump = 2'b10 // jump target from IR
	} pcSrcT;

	typedef enum logic [stateW-1:0]
	{
		stReset,
		stFetch,
		stFetchWait1,
		stFetchWait2,
		stDecode,
		stAluExec,
		stRegWb,
		stNop,
		stBrk,
		stBranchCmp,
		stBeqResolve,
		stBneResolve,
		stJump
	} ctrlStateT;

endpackage : mipsCtrlPkg

`default_nettype wire

// File: sim.f
mipsCtrlPkg.sv
instrDecode.sv
controlFsm.sv
ctrlSignalGen.sv
mipsControl.sv
mipsControl_asserts.sv
mipsControlTb.sv
